/* common/uart_pkg.sv */
package uart_pkg;

    // bus geometry
    localparam int bus_width  = 32;
    localparam int addr_width = 2;

    typedef logic [7:0] uart_byte_t;

    // register map, one byte per register
    typedef enum logic [addr_width-1:0] {
        REG_TXD     = 2'd0,
        REG_RXD     = 2'd1,
        REG_TXQ_RDY = 2'd2,
        REG_RXQ_RDY = 2'd3
    } reg_addr_e;

    // only single-byte accesses are accepted
    typedef enum logic [1:0] {
        ACC_1B = 2'd0,
        ACC_2B = 2'd1,
        ACC_4B = 2'd2
    } bus_acc_e;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int depth = 8
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 push,
    input  uart_pkg::uart_byte_t din,
    input  logic                 pop,
    output uart_pkg::uart_byte_t dout,
    output logic                 full,
    output logic                 empty
);
    import uart_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    uart_byte_t       mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == cnt_w'(depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // first word fall through
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full)
        else $error("sync_fifo: push while full, byte dropped");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty)
        else $error("sync_fifo: pop while empty");

endmodule

/* uart/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int sys_clk_hz = 50_000_000,
    parameter int baud_rate  = 3_125_000
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 byte_valid
);
    import uart_pkg::*;

    localparam int clks_per_bit = sys_clk_hz / baud_rate;
    localparam int cnt_w        = $clog2(clks_per_bit);
    localparam int filt_len     = 5;
    // edge filter latency pulls the start recheck earlier
    localparam int half_chk     = clks_per_bit / 2 - filt_len + 1;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

    rx_state_e           state;
    logic [filt_len-1:0] line_sr;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_cnt;
    logic                fall;
    logic                bit_end;
    logic                vote;

    // two highs then three lows
    assign fall    = (line_sr == 5'b11000);
    assign bit_end = (cnt == cnt_w'(clks_per_bit - 1));
    // majority of the three newest samples
    assign vote    = (line_sr[2] & line_sr[1]) | (line_sr[1] & line_sr[0]) |
                     (line_sr[2] & line_sr[0]);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_sr    <= '1;
            state      <= IDLE;
            cnt        <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            line_sr    <= {line_sr[filt_len-2:0], rx};
            byte_valid <= 1'b0;
            cnt        <= (state == IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (fall) begin
                        state <= START;
                    end
                end
                START: begin
                    // line back high at mid start bit means a glitch
                    if (cnt == cnt_w'(half_chk)) begin
                        state   <= line_sr[0] ? IDLE : DATA;
                        cnt     <= '0;
                        bit_cnt <= '0;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state      <= IDLE;
                        byte_valid <= vote;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && bit_end) begin
            rx_byte <= {vote, rx_byte[7:1]};
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        byte_valid |=> !byte_valid)
        else $error("uart_rx: byte_valid held longer than one cycle");

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int sys_clk_hz = 50_000_000,
    parameter int baud_rate  = 3_125_000
) (
    input  logic                 clk,
    input  logic                 rstn,
    output logic                 tx,
    output logic                 busy,
    output logic                 pop,
    input  logic                 empty,
    input  uart_pkg::uart_byte_t tx_byte
);
    import uart_pkg::*;

    localparam int clks_per_bit = sys_clk_hz / baud_rate;
    localparam int div_w        = $clog2(clks_per_bit);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;

    tx_state_e        state;
    logic [div_w-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    uart_byte_t       shifter;
    logic             bit_end;

    assign bit_end = (div_cnt == div_w'(clks_per_bit - 1));
    // take the next byte as soon as the line is free
    assign pop     = (state == IDLE) && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
            tx      <= 1'b1;
        end else begin
            div_cnt <= (state == IDLE || bit_end) ? '0 : div_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (pop) begin
                        state <= START;
                        busy  <= 1'b1;
                        tx    <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_cnt <= '0;
                        tx      <= shifter[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx <= shifter[0];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shifter <= tx_byte;
        end else if (bit_end && (state == START || state == DATA)) begin
            shifter <= {1'b0, shifter[7:1]};
        end
    end

    a_pop_idle: assert property (@(posedge clk) disable iff (!rstn) pop |-> !busy)
        else $error("uart_tx: pop while a frame is in flight");

endmodule

/* design/uart_regs.sv */
`timescale 1ns/1ps

module uart_regs (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [uart_pkg::addr_width-1:0]   addr,
    input  logic                              w_rb,
    input  uart_pkg::bus_acc_e                acc,
    input  logic [uart_pkg::bus_width-1:0]    wdata,
    input  logic                              req,
    output logic [uart_pkg::bus_width-1:0]    rdata,
    output logic                              resp,
    output logic                              fault,
    output logic                              tx_push,
    output uart_pkg::uart_byte_t              tx_byte,
    input  logic                              tx_full,
    output logic                              rx_pop,
    input  uart_pkg::uart_byte_t              rx_head,
    input  logic                              rx_empty
);
    import uart_pkg::*;

    reg_addr_e  reg_addr;
    logic       bad_acc;
    logic       bad_dir;
    logic       bad_state;
    logic       invld;
    logic       valid;
    uart_byte_t rd_next;
    uart_byte_t rd_byte;

    assign reg_addr = reg_addr_e'(addr);

    // TXD is the only writable register, and the only one not readable
    assign bad_acc   = (acc != ACC_1B);
    assign bad_dir   = w_rb ? (reg_addr != REG_TXD) : (reg_addr == REG_TXD);
    assign bad_state = (w_rb && reg_addr == REG_TXD && tx_full) ||
                       (!w_rb && reg_addr == REG_RXD && rx_empty);
    assign invld     = bad_acc || bad_dir || bad_state;

    assign fault = req && invld;
    assign valid = req && !invld;

    assign tx_push = valid && w_rb && (reg_addr == REG_TXD);
    assign tx_byte = wdata[7:0];
    assign rx_pop  = valid && !w_rb && (reg_addr == REG_RXD);

    always_comb begin
        case (reg_addr)
            REG_RXD:     rd_next = rx_head;
            REG_TXQ_RDY: rd_next = {7'd0, !tx_full};
            REG_RXQ_RDY: rd_next = {7'd0, !rx_empty};
            default:     rd_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp <= 1'b0;
        end else begin
            resp <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !w_rb) begin
            rd_byte <= rd_next;
        end
    end

    assign rdata = {{(bus_width - 8){1'b0}}, rd_byte};

    // master never overlaps a req with the previous resp
    a_fault_resp: assert property (@(posedge clk) disable iff (!rstn) !(fault && resp))
        else $error("uart_regs: fault and resp high together");
    a_pop_nonempty: assert property (@(posedge clk) disable iff (!rstn) rx_pop |-> !rx_empty)
        else $error("uart_regs: rx_pop on empty receive FIFO");

endmodule

/* design/uart_controller.sv */
`timescale 1ns/1ps

module uart_controller #(
    parameter int sys_clk_hz = 50_000_000,
    parameter int baud_rate  = 3_125_000,
    parameter int fifo_depth = 8
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            rx,
    output logic                            tx,
    input  logic [uart_pkg::addr_width-1:0] addr,
    input  logic                            w_rb,
    input  uart_pkg::bus_acc_e              acc,
    input  logic [uart_pkg::bus_width-1:0]  wdata,
    input  logic                            req,
    output logic [uart_pkg::bus_width-1:0]  rdata,
    output logic                            resp,
    output logic                            fault
);
    import uart_pkg::*;

    // register side
    logic       tx_push;
    uart_byte_t tx_byte;
    logic       tx_full;
    logic       rx_pop;
    uart_byte_t rx_head;
    logic       rx_empty;

    // line side
    uart_byte_t rx_byte;
    logic       byte_valid;
    uart_byte_t tx_head;
    logic       tx_empty;
    logic       tx_pop;

    uart_regs u_regs (
        .clk      (clk),
        .rstn     (rstn),
        .addr     (addr),
        .w_rb     (w_rb),
        .acc      (acc),
        .wdata    (wdata),
        .req      (req),
        .rdata    (rdata),
        .resp     (resp),
        .fault    (fault),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .tx_full  (tx_full),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_empty (rx_empty)
    );

    uart_rx #(.sys_clk_hz(sys_clk_hz), .baud_rate(baud_rate)) u_rx (
        .clk        (clk),
        .rstn       (rstn),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid)
    );

    // overflow drops the byte, flagged inside the FIFO
    sync_fifo #(.depth(fifo_depth)) rx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (byte_valid),
        .din   (rx_byte),
        .pop   (rx_pop),
        .dout  (rx_head),
        .full  (),
        .empty (rx_empty)
    );

    sync_fifo #(.depth(fifo_depth)) tx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (tx_push),
        .din   (tx_byte),
        .pop   (tx_pop),
        .dout  (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    uart_tx #(.sys_clk_hz(sys_clk_hz), .baud_rate(baud_rate)) u_tx (
        .clk     (clk),
        .rstn    (rstn),
        .tx      (tx),
        .busy    (),
        .pop     (tx_pop),
        .empty   (tx_empty),
        .tx_byte (tx_head)
    );

endmodule

/* test/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rstn
);
    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

/* test/tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;
    import uart_pkg::*;

    localparam int fifo_depth    = 8;
    localparam int bit_clks      = 16;
    localparam int resp_timeout  = 4;
    localparam int poll_limit    = 64;
    localparam int frame_timeout = 12 * bit_clks;

    logic                  clk;
    logic                  rstn;
    logic                  rx;
    logic                  tx;
    logic [addr_width-1:0] addr;
    logic                  w_rb;
    bus_acc_e              acc;
    logic [bus_width-1:0]  wdata;
    logic                  req;
    logic [bus_width-1:0]  rdata;
    logic                  resp;
    logic                  fault;
    int                    seed = 48256;

    clk_gen u_clk (.clk(clk), .rstn(rstn));

    uart_controller #(
        .sys_clk_hz (50_000_000),
        .baud_rate  (3_125_000),
        .fifo_depth (fifo_depth)
    ) dut (
        .clk   (clk),
        .rstn  (rstn),
        .rx    (rx),
        .tx    (tx),
        .addr  (addr),
        .w_rb  (w_rb),
        .acc   (acc),
        .wdata (wdata),
        .req   (req),
        .rdata (rdata),
        .resp  (resp),
        .fault (fault)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // a legal access gets resp and no fault, an illegal one the reverse
    task automatic check_fault(input string name, input logic got_fault, input logic got_resp,
                               input logic exp_fault);
        check_flag({name, " fault"}, got_fault, exp_fault);
        check_flag({name, " resp"}, got_resp, !exp_fault);
    endtask

    task automatic bus_access(input reg_addr_e a, input logic wr, input bus_acc_e size,
                              input uart_byte_t data, output logic got_fault,
                              output logic got_resp, output logic [bus_width-1:0] got_rdata);
        int i;
        @(posedge clk);
        addr  <= a;
        w_rb  <= wr;
        acc   <= size;
        wdata <= bus_width'(data);
        req   <= 1'b1;
        @(negedge clk);
        got_fault = fault;
        @(posedge clk);
        req       <= 1'b0;
        got_resp  = 1'b0;
        got_rdata = '0;
        for (i = 0; i < resp_timeout; i++) begin
            @(negedge clk);
            if (resp) begin
                got_resp  = 1'b1;
                got_rdata = rdata;
                break;
            end
        end
        // resp belongs in the cycle right after req
        if (got_resp && i != 0) begin
            report_failure($sformatf("Mismatch at %0t: resp latency got %0d expected 1",
                                     $time, i + 1));
        end
    endtask

    task automatic write_byte(input uart_byte_t data, input logic exp_fault);
        logic                 f;
        logic                 r;
        logic [bus_width-1:0] d;
        bus_access(REG_TXD, 1'b1, ACC_1B, data, f, r, d);
        check_fault("TXD write", f, r, exp_fault);
    endtask

    task automatic read_reg(input reg_addr_e a, output uart_byte_t val);
        logic                 f;
        logic                 r;
        logic [bus_width-1:0] d;
        bus_access(a, 1'b0, ACC_1B, 8'h00, f, r, d);
        check_fault({a.name(), " read"}, f, r, 1'b0);
        check_flag("rdata upper bits zero", d[bus_width-1:8] == '0, 1'b1);
        val = d[7:0];
    endtask

    task automatic hold_line(input logic level, input int clks);
        @(posedge clk);
        rx <= level;
        repeat (clks - 1) @(posedge clk);
    endtask

    task automatic send_frame(input uart_byte_t b);
        int stop_len;
        int i;
        stop_len = bit_clks + ($unsigned($random(seed)) % 8);
        hold_line(1'b0, bit_clks);
        for (i = 0; i < 8; i++) begin
            hold_line(b[i], bit_clks);
        end
        hold_line(1'b1, stop_len);
    endtask

    // samples each bit of a tx frame near its centre
    task automatic decode_frame(output uart_byte_t b);
        int   i;
        logic seen;
        seen = 1'b0;
        for (i = 0; i < frame_timeout; i++) begin
            @(negedge clk);
            if (tx === 1'b0) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            report_failure("timed out waiting for a start bit on tx");
        end
        repeat (bit_clks / 2) @(negedge clk);
        check_flag("tx start bit", tx, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            b[i] = tx;
        end
        repeat (bit_clks) @(negedge clk);
        check_flag("tx stop bit", tx, 1'b1);
    endtask

    task automatic do_transmit(input uart_byte_t b);
        uart_byte_t got;
        write_byte(b, 1'b0);
        decode_frame(got);
        check_byte("tx byte", got, b);
    endtask

    task automatic do_receive(input uart_byte_t b);
        uart_byte_t v;
        int         i;
        send_frame(b);
        v = 8'h00;
        for (i = 0; i < poll_limit; i++) begin
            read_reg(REG_RXQ_RDY, v);
            if (v[0]) begin
                break;
            end
        end
        if (!v[0]) begin
            report_failure("timed out waiting for RXQ_RDY to read 1");
        end
        read_reg(REG_RXD, v);
        check_byte("RXD", v, b);
        read_reg(REG_RXQ_RDY, v);
        check_flag("RXQ_RDY after read", v[0], 1'b0);
    endtask

    task automatic do_glitch(input uart_byte_t b);
        uart_byte_t v;
        hold_line(1'b0, bit_clks / 4);
        // long enough for a false frame to finish
        hold_line(1'b1, 12 * bit_clks);
        read_reg(REG_RXQ_RDY, v);
        check_flag("RXQ_RDY after glitch", v[0], 1'b0);
        do_receive(b);
    endtask

    // one byte sits in the transmitter, the rest fill the FIFO
    task automatic do_fill(input uart_byte_t first);
        uart_byte_t sent[$];
        uart_byte_t got[$];
        uart_byte_t val;
        uart_byte_t flags;
        uart_byte_t frame;
        logic       full_seen;
        int         i;
        int         k;
        full_seen = 1'b0;
        fork
            begin
                for (i = 0; i < fifo_depth + 2 && !full_seen; i++) begin
                    val = uart_byte_t'(first + i);
                    write_byte(val, 1'b0);
                    sent.push_back(val);
                    read_reg(REG_TXQ_RDY, flags);
                    full_seen = !flags[0];
                end
                if (!full_seen) begin
                    report_failure("TXQ_RDY never read 0 while filling the transmit FIFO");
                end
                write_byte(uart_byte_t'(first + i), 1'b1);
            end
            begin
                for (k = 0; k < fifo_depth + 1; k++) begin
                    decode_frame(frame);
                    got.push_back(frame);
                end
            end
        join
        if (sent.size() != got.size()) begin
            report_failure($sformatf("Mismatch at %0t: accepted byte count got %0d expected %0d",
                                     $time, got.size(), sent.size()));
        end
        for (k = 0; k < sent.size(); k++) begin
            check_byte($sformatf("tx byte %0d after fill", k), got[k], sent[k]);
        end
    endtask

    task automatic illegal_case(input int n);
        logic                 f;
        logic                 r;
        logic [bus_width-1:0] d;
        case (n)
            0: bus_access(REG_TXD, 1'b1, ACC_2B, 8'h11, f, r, d);
            1: bus_access(REG_RXQ_RDY, 1'b0, ACC_4B, 8'h00, f, r, d);
            2: bus_access(REG_RXD, 1'b1, ACC_1B, 8'h22, f, r, d);
            3: bus_access(REG_TXQ_RDY, 1'b1, ACC_1B, 8'h33, f, r, d);
            4: bus_access(REG_TXD, 1'b0, ACC_1B, 8'h00, f, r, d);
            // receive FIFO is drained by now
            5: bus_access(REG_RXD, 1'b0, ACC_1B, 8'h00, f, r, d);
            default: report_failure($sformatf("unknown illegal access case %0d", n));
        endcase
        check_fault($sformatf("illegal case %0d", n), f, r, 1'b1);
    endtask

    initial begin
        int    fd;
        int    code;
        int    i;
        int    val;
        byte   op;
        string line;
        rx    = 1'b1;
        addr  = '0;
        w_rb  = 1'b0;
        acc   = ACC_1B;
        wdata = '0;
        req   = 1'b0;
        for (i = 0; i < 10 && rstn !== 1'b1; i++) begin
            @(negedge clk);
        end
        if (rstn !== 1'b1) begin
            report_failure("reset was never released");
        end
        check_flag("tx after reset", tx, 1'b1);
        check_flag("resp after reset", resp, 1'b0);
        check_flag("fault after reset", fault, 1'b0);
        fd = $fopen("test/uart_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("could not open test/uart_patterns.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            code = $sscanf(line, "%c %h", op, val);
            if (code != 2 || op == "#") begin
                continue;
            end
            case (op)
                "T": do_transmit(uart_byte_t'(val));
                "R": do_receive(uart_byte_t'(val));
                "G": do_glitch(uart_byte_t'(val));
                "F": do_fill(uart_byte_t'(val));
                "X": illegal_case(val);
                default: report_failure($sformatf("unknown opcode %c in pattern file", op));
            endcase
        end
        $fclose(fd);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* files.f */
common/uart_pkg.sv
design/sync_fifo.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/uart_regs.sv
design/uart_controller.sv
test/clk_gen.sv
test/tb_uart.sv

/* test/uart_patterns.txt */
# op byte: T write byte and expect it on tx, R drive byte on rx and read it back
# G glitch then frame with byte, F fill tx FIFO from byte, X illegal access case
T A5
T 3C
R 5A
R C3
X 00
X 01
X 02
X 03
X 04
X 05
G 96
F 10
